/* image_core_patterns.txt */
# Columns: kind (H host word, R expected readback word, C expected loaded count) and a hex value
# Header: last[31] count[25:17] bank[16:9] addr[8:0]; data: row1[17:9] row0[8:0]
H 00040000  header bank 0 addr 0 count 2
H 000202a5  bank 0 addr 0
H 0001ffff  bank 0 addr 1
H 00020200  header bank 1 addr 0 count 1
H 00002222  bank 1 addr 0
H 00020400  header bank 2 addr 0 count 1
H 00006644  bank 2 addr 0
H 00020600  header bank 3 addr 0 count 1
H 0000aa66  bank 3 addr 0
H 00020800  header bank 4 addr 0 count 1
H 0000ee88  bank 4 addr 0
H 00020a00  header bank 5 addr 0 count 1
H 000332aa  bank 5 addr 0
H 00020c00  header bank 6 addr 0 count 1
H 000377cc  bank 6 addr 0
H 00020e00  header bank 7 addr 0 count 1
H 0001bbee  bank 7 addr 0
H 00021000  header bank 8 addr 0 count 1
H 0003ffff  bank 8 is out of range, dropped
H 000407df  header bank 3 addr 479 count 2
H 00024645  bank 3 addr 479
H 00015555  bank 3 addr 480 is out of range, dropped
H 80020000  last header, verify count 1
R 000202a5  bank 0 addr 0
R 00002222  bank 1 addr 0
R 00006644  bank 2 addr 0
R 0000aa66  bank 3 addr 0
R 0000ee88  bank 4 addr 0
R 000332aa  bank 5 addr 0
R 000377cc  bank 6 addr 0
R 0001bbee  bank 7 addr 0
C 0000000a  words written

/* project.f */
+incdir+.
image_pkg.sv
image_bank_array.sv
load_unit.sv
readback_unit.sv
phase_sequencer.sv
hex_display.sv
image_core_top.sv
image_core_asserts.sv
image_core_tb.sv

/* Bender.yml */
package:
  name: image_core

export_include_dirs:
  - .

sources:
  - files:
      - image_pkg.sv
      - image_bank_array.sv
      - load_unit.sv
      - readback_unit.sv
      - phase_sequencer.sv
      - hex_display.sv
      - image_core_top.sv
  - target: test
    files:
      - image_core_asserts.sv
      - image_core_tb.sv

/* image_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module image_core_tb;

	logic                   CLOCK_50;
	logic                   reset;
	logic                   host_val;
	image_pkg::host_word_u  host_data;
	logic                   host_ack;
	logic                   fpga_val;
	image_pkg::host_word_u  fpga_data;
	image_pkg::hex_digits_t hex;
	image_pkg::seq_status_t ledr;

	// Records from the pattern file
	image_pkg::host_word_u host_words[$];
	image_pkg::host_word_u expected_words[$];
	logic [15:0] expected_count;
	int record_count = 0;
	int error_count = 0;
	int cycle_limit = 0;
	int cycles = 0;

	// Status words with fields load, verify, done, rd_val
	localparam image_pkg::seq_status_t load_only = 4'b1000;
	localparam image_pkg::seq_status_t verify_showing = 4'b0101;
	localparam image_pkg::seq_status_t done_only = 4'b0010;

	image_core_top image_core_top_i (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.host_val  (host_val),
		.host_data (host_data),
		.host_ack  (host_ack),
		.fpga_val  (fpga_val),
		.fpga_data (fpga_data),
		.hex       (hex),
		.ledr      (ledr)
	);

	bind image_core_top image_core_asserts image_core_asserts_i (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.ledr         (ledr),
		.mem_port     (mem_port),
		.verify_start (verify_start),
		.fpga_val     (fpga_val),
		.fpga_data    (fpga_data),
		.host_ack     (host_ack)
	);

	////////////////////
	// Reporting and checks
	////////////////////

	task automatic report_failure(input string line);
		error_count++;
		$display("%s", line);
		$display("** FAIL **");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_readback_word(input image_pkg::host_word_u got,
			input image_pkg::host_word_u exp, input int index);
		if (got !== exp) begin
			report_failure($sformatf("FAIL @ %0d ns: readback word %0d is %h, expected %h",
				$time, index, got, exp));
		end
	endtask

	task automatic verify_hex_digits(input image_pkg::hex_digits_t got,
			input image_pkg::hex_digits_t exp);
		if (got !== exp) begin
			report_failure($sformatf("FAIL @ %0d ns: hex segments %h, expected %h",
				$time, got, exp));
		end
	endtask

	task automatic expect_status(input image_pkg::seq_status_t got,
			input image_pkg::seq_status_t exp, input string where);
		if (got !== exp) begin
			report_failure($sformatf("FAIL @ %0d ns: status %b during %s, expected %b",
				$time, got, where, exp));
		end
	endtask

	// Lit segments gfedcba of one hex digit inverted for the display
	function automatic logic [6:0] segments_for(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	// Digit 0 shows the low nibble
	function automatic image_pkg::hex_digits_t hex_for_count(input logic [15:0] count);
		image_pkg::hex_digits_t digits;
		for (int i = 0; i < 4; i++) begin
			digits[i] = segments_for(count[4*i +: 4]);
		end
		return digits;
	endfunction

	////////////////////
	// Pattern file
	////////////////////

	// H host word, R expected readback word, C expected loaded count
	task automatic load_patterns();
		int fd;
		int fields;
		string line;
		logic [7:0] kind;
		logic [31:0] value;
		fd = $fopen("image_core_patterns.txt", "r");
		if (fd == 0) begin
			report_failure("could not open image_core_patterns.txt");
		end
		while ($fgets(line, fd) != 0) begin
			fields = $sscanf(line, "%c %h", kind, value);
			// Comments and blank lines
			if (fields == 2 && kind != "#") begin
				record_count++;
				case (kind)
					"H": host_words.push_back(value);
					"R": expected_words.push_back(value);
					"C": expected_count = value[15:0];
					default: report_failure($sformatf("unknown pattern record: %s", line));
				endcase
			end
		end
		$fclose(fd);
	endtask

	////////////////////
	// Host side
	////////////////////

	// One-cycle valid pulse from a falling edge
	task automatic send_host_word(input image_pkg::host_word_u word);
		host_data = word;
		host_val  = 1'b1;
		@(negedge CLOCK_50);
		host_val  = 1'b0;
	endtask

	task automatic await_readback(input int index);
		while (fpga_val !== 1'b1) begin
			if (ledr.done === 1'b1) begin
				report_failure($sformatf("readback ended after %0d of %0d words",
					index, expected_words.size()));
			end
			@(negedge CLOCK_50);
		end
	endtask

	// Random hold with a stable word before the acknowledge pulse
	task automatic ack_after_delay();
		int unsigned delay;
		image_pkg::host_word_u held;
		delay = $urandom % 6;
		held  = fpga_data;
		repeat (delay) begin
			@(negedge CLOCK_50);
			if (fpga_val !== 1'b1 || fpga_data !== held) begin
				report_failure("readback word was withdrawn before its acknowledge");
			end
		end
		host_ack = 1'b1;
		@(negedge CLOCK_50);
		host_ack = 1'b0;
	endtask

	////////////////////
	// Clock and watchdog
	////////////////////

	initial begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50;
	end

	// Limit is known before the first edge
	initial begin
		@(posedge CLOCK_50);
		while (cycles < cycle_limit) begin
			@(posedge CLOCK_50);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", cycles);
		$display("** FAIL **");
		$fatal(1, "simulation timed out");
	end

	// Bound assertions tally their failures
	always @(posedge CLOCK_50) begin
		if (image_core_top_i.image_core_asserts_i.failures != 0) begin
			report_failure("a bound assertion on the DUT failed");
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		reset     = 1'b1;
		host_val  = 1'b0;
		host_data = '0;
		host_ack  = 1'b0;
		void'($urandom(32'haaad_0257));
		load_patterns();
		cycle_limit = record_count * 10 + 200;

		repeat (16) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		reset = 1'b0;
		// Load phase starts on the next edge
		@(negedge CLOCK_50);

		foreach (host_words[i]) begin
			expect_status(ledr, load_only, "loading");
			send_host_word(host_words[i]);
		end
		verify_hex_digits(hex, hex_for_count(expected_count));

		// Bank-major readback
		for (int i = 0; i < expected_words.size(); i++) begin
			await_readback(i);
			expect_status(ledr, verify_showing, "readback");
			check_readback_word(fpga_data, expected_words[i], i);
			ack_after_delay();
		end

		while (ledr.done !== 1'b1) begin
			if (fpga_val === 1'b1) begin
				report_failure("readback offered more words than expected");
			end
			@(negedge CLOCK_50);
		end
		expect_status(ledr, done_only, "the done phase");
		repeat (4) begin
			@(negedge CLOCK_50);
			if (fpga_val !== 1'b0) begin
				report_failure("readback word appeared after the done phase");
			end
		end
		verify_hex_digits(hex, hex_for_count(expected_count));

		if (error_count == 0 && image_core_top_i.image_core_asserts_i.failures == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* image_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module image_core_asserts (
	input  wire logic                  CLOCK_50,
	input  wire logic                  reset,
	input  wire image_pkg::seq_status_t ledr,
	input  wire image_pkg::bank_port_t  mem_port,
	input  wire logic                  verify_start,
	input  wire logic                  fpga_val,
	input  wire image_pkg::host_word_u fpga_data,
	input  wire logic                  host_ack
);

	// Failed properties so far, the testbench watches this
	int unsigned failures = 0;
	// Phase as a rank, reset lowest and done highest
	logic [1:0] rank;

	always_comb begin
		if (ledr.done) begin
			rank = 2'd3;
		end else if (ledr.verify) begin
			rank = 2'd2;
		end else if (ledr.load) begin
			rank = 2'd1;
		end else begin
			rank = 2'd0;
		end
	end

	////////////////////
	// Phase order
	////////////////////

	// Phase only ever steps forward until the next reset
	phase_forward: assert property (@(posedge CLOCK_50) disable iff (reset)
		rank >= $past(rank))
	else begin
		$error("phase moved backward");
		failures++;
	end

	// Bank writes belong to the load phase
	write_in_load: assert property (@(posedge CLOCK_50) disable iff (reset)
		mem_port.we |-> ledr.load)
	else begin
		$error("bank write outside the load phase");
		failures++;
	end

	////////////////////
	// Strobes
	////////////////////

	// Readback word held until the host acknowledges it
	readback_held: assert property (@(posedge CLOCK_50) disable iff (reset)
		fpga_val && !host_ack |=> fpga_val && $stable(fpga_data))
	else begin
		$error("readback word dropped or changed before acknowledge");
		failures++;
	end

	// Single-cycle start pulse
	start_pulse: assert property (@(posedge CLOCK_50) disable iff (reset)
		verify_start |=> !verify_start)
	else begin
		$error("verify_start held longer than one cycle");
		failures++;
	end

endmodule

`default_nettype wire

/* image_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_consts.svh"

module image_core_top (
	input  wire logic                  CLOCK_50,
	input  wire logic                  reset,
	input  wire logic                  host_val,
	input  wire image_pkg::host_word_u host_data,
	input  wire logic                  host_ack,
	output logic                       fpga_val,
	output image_pkg::host_word_u      fpga_data,
	output image_pkg::hex_digits_t     hex,
	output image_pkg::seq_status_t     ledr
);

	// Bank ports, one per client plus the arbitrated one
	image_pkg::bank_port_t load_port;
	image_pkg::bank_port_t read_port;
	image_pkg::bank_port_t mem_port;

	logic [2*`IMG_PIXEL_W-1:0] rdata;

	// Phase handoff strobes
	logic load_done;
	logic verify_start;
	logic verify_done;

	logic [`IMG_ADDR_W-1:0] verify_count;
	logic [15:0] loaded_count;

	////////////////////
	// Control
	////////////////////

	phase_sequencer phase_sequencer_i (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.load_done    (load_done),
		.verify_done  (verify_done),
		.load_port    (load_port),
		.read_port    (read_port),
		.fpga_val     (fpga_val),
		.mem_port     (mem_port),
		.verify_start (verify_start),
		.status       (ledr)
	);

	////////////////////
	// Datapath
	////////////////////

	load_unit load_unit_i (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.host_val     (host_val),
		.host_data    (host_data),
		.port         (load_port),
		.load_done    (load_done),
		.verify_count (verify_count),
		.loaded_count (loaded_count)
	);

	readback_unit readback_unit_i (
		.CLOCK_50     (CLOCK_50),
		.reset        (reset),
		.verify_start (verify_start),
		.verify_count (verify_count),
		.rdata        (rdata),
		.host_ack     (host_ack),
		.port         (read_port),
		.fpga_val     (fpga_val),
		.fpga_data    (fpga_data),
		.verify_done  (verify_done)
	);

	image_bank_array image_bank_array_i (
		.CLOCK_50 (CLOCK_50),
		.port     (mem_port),
		.rdata    (rdata)
	);

	// Loaded-word count on four digits
	hex_display hex_display_i (
		.loaded_count (loaded_count),
		.hex          (hex)
	);

endmodule

`default_nettype wire

/* hex_display.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_display (
	input  wire logic [15:0]       loaded_count,
	output image_pkg::hex_digits_t hex
);

	// Segments gfedcba, low means lit
	function automatic logic [6:0] seg7(input logic [3:0] nib);
		case (nib)
			4'h0: seg7 = 7'b1000000;
			4'h1: seg7 = 7'b1111001;
			4'h2: seg7 = 7'b0100100;
			4'h3: seg7 = 7'b0110000;
			4'h4: seg7 = 7'b0011001;
			4'h5: seg7 = 7'b0010010;
			4'h6: seg7 = 7'b0000010;
			4'h7: seg7 = 7'b1111000;
			4'h8: seg7 = 7'b0000000;
			4'h9: seg7 = 7'b0010000;
			4'ha: seg7 = 7'b0001000;
			4'hb: seg7 = 7'b0000011;
			4'hc: seg7 = 7'b1000110;
			4'hd: seg7 = 7'b0100001;
			4'he: seg7 = 7'b0000110;
			default: seg7 = 7'b0001110;
		endcase
	endfunction

	////////////////////
	// One digit per nibble
	////////////////////

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			hex[i] = seg7(loaded_count[4*i +: 4]);
		end
	end

endmodule

`default_nettype wire

/* phase_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer (
	input  wire logic                  CLOCK_50,
	input  wire logic                  reset,
	input  wire logic                  load_done,
	input  wire logic                  verify_done,
	input  wire image_pkg::bank_port_t load_port,
	input  wire image_pkg::bank_port_t read_port,
	input  wire logic                  fpga_val,
	output image_pkg::bank_port_t      mem_port,
	output logic                       verify_start,
	output image_pkg::seq_status_t     status
);

	image_pkg::phase_e phase;

	////////////////////
	// Phase FSM
	////////////////////

	always_ff @(posedge CLOCK_50) begin
		verify_start <= 1'b0;
		if (reset) begin
			phase <= image_pkg::PH_RESET;
		end else begin
			case (phase)
				// Leave reset on the first free edge
				image_pkg::PH_RESET: phase <= image_pkg::PH_LOAD;
				image_pkg::PH_LOAD: begin
					if (load_done) begin
						phase        <= image_pkg::PH_VERIFY;
						verify_start <= 1'b1;
					end
				end
				image_pkg::PH_VERIFY: begin
					if (verify_done) begin
						phase <= image_pkg::PH_DONE;
					end
				end
				// Terminal until the next reset
				default: phase <= image_pkg::PH_DONE;
			endcase
		end
	end

	////////////////////
	// Bank port select
	////////////////////

	always_comb begin
		case (phase)
			image_pkg::PH_LOAD:   mem_port = load_port;
			image_pkg::PH_VERIFY: mem_port = read_port;
			default: begin
				// Reads allowed, writes blocked
				mem_port    = read_port;
				mem_port.we = 1'b0;
			end
		endcase
	end

	// LED flags
	always_comb begin
		status.load   = (phase == image_pkg::PH_LOAD);
		status.verify = (phase == image_pkg::PH_VERIFY);
		status.done   = (phase == image_pkg::PH_DONE);
		status.rd_val = fpga_val;
	end

endmodule

`default_nettype wire

/* readback_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_consts.svh"

module readback_unit (
	input  wire logic                     CLOCK_50,
	input  wire logic                     reset,
	input  wire logic                     verify_start,
	input  wire logic [`IMG_ADDR_W-1:0]   verify_count,
	input  wire logic [2*`IMG_PIXEL_W-1:0] rdata,
	input  wire logic                     host_ack,
	output image_pkg::bank_port_t         port,
	output logic                          fpga_val,
	output image_pkg::host_word_u         fpga_data,
	output logic                          verify_done
);

	// Idle, wait for read, show word, finished
	typedef enum logic [1:0] {
		RB_IDLE,
		RB_WAIT,
		RB_SHOW,
		RB_FIN
	} rb_state_e;

	rb_state_e state;
	logic [`IMG_BANK_W-1:0] bank_q;
	logic [`IMG_ADDR_W-1:0] addr_q;
	logic last_addr;
	logic last_bank;

	assign last_addr = (addr_q == verify_count - 1'b1);
	assign last_bank = (bank_q == `IMG_BANK_W'(`IMG_BANK_COUNT - 1));

	////////////////////
	// Host side
	////////////////////

	// Address held while shown, so the word stays stable
	assign fpga_val = (state == RB_SHOW);

	always_comb begin
		fpga_data.data.pad  = '0;
		fpga_data.data.row1 = rdata[2*`IMG_PIXEL_W-1:`IMG_PIXEL_W];
		fpga_data.data.row0 = rdata[`IMG_PIXEL_W-1:0];
	end

	// Read only
	always_comb begin
		port.bank  = bank_q;
		port.addr  = addr_q;
		port.wdata = '0;
		port.we    = 1'b0;
	end

	////////////////////
	// Walk banks, then addresses
	////////////////////

	always_ff @(posedge CLOCK_50) begin
		verify_done <= 1'b0;
		if (reset) begin
			state  <= RB_IDLE;
			bank_q <= '0;
			addr_q <= '0;
		end else begin
			case (state)
				RB_IDLE: begin
					if (verify_start) begin
						bank_q <= '0;
						addr_q <= '0;
						if (verify_count == '0) begin
							// Nothing to read back
							verify_done <= 1'b1;
							state       <= RB_FIN;
						end else begin
							state <= RB_WAIT;
						end
					end
				end
				// One cycle of read latency
				RB_WAIT: state <= RB_SHOW;
				RB_SHOW: begin
					if (host_ack) begin
						if (!last_addr) begin
							addr_q <= addr_q + 1'b1;
							state  <= RB_WAIT;
						end else if (!last_bank) begin
							bank_q <= bank_q + 1'b1;
							addr_q <= '0;
							state  <= RB_WAIT;
						end else begin
							verify_done <= 1'b1;
							state       <= RB_FIN;
						end
					end
				end
				default: state <= RB_FIN;
			endcase
		end
	end

endmodule

`default_nettype wire

/* load_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_consts.svh"

module load_unit (
	input  wire logic                  CLOCK_50,
	input  wire logic                  reset,
	input  wire logic                  host_val,
	input  wire image_pkg::host_word_u host_data,
	output image_pkg::bank_port_t      port,
	output logic                       load_done,
	output logic [`IMG_ADDR_W-1:0]     verify_count,
	output logic [15:0]                loaded_count
);

	// Next host word is a header
	logic expect_hdr;
	// Last header seen and rest of the stream ignored
	logic load_fin;
	// Current block
	logic [`IMG_BANK_W-1:0] bank_q;
	// One extra bit so a long block cannot wrap into range
	logic [`IMG_ADDR_W:0] addr_q;
	logic [`IMG_ADDR_W-1:0] remaining;
	// Data word lands inside the memory
	logic in_range;
	logic take_data;

	assign in_range = (bank_q < `IMG_BANK_COUNT) && (addr_q < `IMG_BANK_DEPTH);
	assign take_data = host_val && !expect_hdr && !load_fin;

	////////////////////
	// Bank write
	////////////////////

	// Write on the sampling edge itself
	always_comb begin
		port.bank  = bank_q;
		port.addr  = addr_q[`IMG_ADDR_W-1:0];
		port.wdata = {host_data.data.row1, host_data.data.row0};
		port.we    = take_data && in_range;
	end

	////////////////////
	// Stream decode
	////////////////////

	always_ff @(posedge CLOCK_50) begin
		load_done <= 1'b0;
		if (reset) begin
			expect_hdr   <= 1'b1;
			load_fin     <= 1'b0;
			verify_count <= '0;
			loaded_count <= '0;
		end else if (host_val && !load_fin) begin
			if (expect_hdr) begin
				if (host_data.hdr.last) begin
					// Closing header carries the readback length
					load_fin     <= 1'b1;
					load_done    <= 1'b1;
					verify_count <= host_data.hdr.count;
				end else begin
					// Empty block stays on headers
					expect_hdr <= (host_data.hdr.count == '0);
				end
			end else begin
				// Dropped words are not tallied
				if (in_range) begin
					loaded_count <= loaded_count + 16'd1;
				end
				if (remaining == `IMG_ADDR_W'(1)) begin
					expect_hdr <= 1'b1;
				end
			end
		end
	end

	// Block position taken from each header
	always_ff @(posedge CLOCK_50) begin
		if (host_val && !load_fin) begin
			if (expect_hdr) begin
				bank_q    <= host_data.hdr.bank;
				addr_q    <= {1'b0, host_data.hdr.addr};
				remaining <= host_data.hdr.count;
			end else begin
				addr_q    <= addr_q + 1'b1;
				remaining <= remaining - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* image_bank_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "image_consts.svh"

module image_bank_array (
	input  wire logic                      CLOCK_50,
	input  wire image_pkg::bank_port_t     port,
	output logic [2*`IMG_PIXEL_W-1:0]      rdata
);

	// Registered read word of every bank
	logic [2*`IMG_PIXEL_W-1:0] bank_q [`IMG_BANK_COUNT];
	// Bank of the read in flight
	logic [`IMG_BANK_W-1:0] rd_bank;

	////////////////////
	// Line memories
	////////////////////

	for (genvar i = 0; i < `IMG_BANK_COUNT; i++) begin : gen_bank
		// One line pair per bank, high half is the second row
		logic [2*`IMG_PIXEL_W-1:0] mem [`IMG_BANK_DEPTH];

		always_ff @(posedge CLOCK_50) begin
			// Write only to the selected bank
			if (port.we && port.bank == `IMG_BANK_W'(i) && port.addr < `IMG_BANK_DEPTH) begin
				mem[port.addr] <= port.wdata;
			end
			// Read returns the old word on a same-address write
			if (port.addr < `IMG_BANK_DEPTH) begin
				bank_q[i] <= mem[port.addr];
			end else begin
				bank_q[i] <= '0;
			end
		end
	end

	////////////////////
	// Read select
	////////////////////

	// Bank select follows the data by one cycle
	always_ff @(posedge CLOCK_50) begin
		rd_bank <= port.bank;
	end

	always_comb begin
		rdata = '0;
		for (int i = 0; i < `IMG_BANK_COUNT; i++) begin
			if (rd_bank == `IMG_BANK_W'(i)) begin
				rdata = bank_q[i];
			end
		end
	end

endmodule

`default_nettype wire

/* image_pkg.sv */
`default_nettype none

`include "image_consts.svh"

package image_pkg;

	////////////////////
	// Phases
	////////////////////

	// Reset, load, verify, done in strict order
	typedef enum logic [1:0] {
		PH_RESET  = 2'd0,
		PH_LOAD   = 2'd1,
		PH_VERIFY = 2'd2,
		PH_DONE   = 2'd3
	} phase_e;

	////////////////////
	// Host word
	////////////////////

	// Header view, opens a block or ends loading
	typedef struct packed {
		logic                   last;
		logic [4:0]             pad;
		logic [`IMG_ADDR_W-1:0] count;
		logic [`IMG_BANK_W-1:0] bank;
		logic [`IMG_ADDR_W-1:0] addr;
	} host_hdr_t;

	// Data view, second row in the high half
	typedef struct packed {
		logic [31-2*`IMG_PIXEL_W:0] pad;
		logic [`IMG_PIXEL_W-1:0]    row1;
		logic [`IMG_PIXEL_W-1:0]    row0;
	} host_data_t;

	// Same 32 bits, meaning set by stream position
	typedef union packed {
		host_hdr_t  hdr;
		host_data_t data;
	} host_word_u;

	////////////////////
	// Bank access
	////////////////////

	typedef struct packed {
		logic [`IMG_BANK_W-1:0]    bank;
		logic [`IMG_ADDR_W-1:0]    addr;
		logic [2*`IMG_PIXEL_W-1:0] wdata;
		logic                      we;
	} bank_port_t;

	// Phase flags plus readback valid, shown on the LEDs
	typedef struct packed {
		logic load;
		logic verify;
		logic done;
		logic rd_val;
	} seq_status_t;

	// Active-low segments, digit 0 in the low slot
	typedef logic [3:0][6:0] hex_digits_t;

endpackage

`default_nettype wire

/* image_consts.svh */
`ifndef IMAGE_CONSTS_SVH
`define IMAGE_CONSTS_SVH

////////////////////
// Memory geometry
////////////////////

// Number of line memories
`define IMG_BANK_COUNT 8

// Words per line memory, one per pixel column
`define IMG_BANK_DEPTH 480

////////////////////
// Field widths
////////////////////

// Word address inside one bank
`define IMG_ADDR_W 9

// Bank index as carried in the host header
`define IMG_BANK_W 8

// One pixel, two of them per stored word
`define IMG_PIXEL_W 9

`endif
